// File: verilog/slurm16_consts.svh
// Widths and class codes are fixed by the SLURM16 encoding and shared by packages and RTL
`ifndef SLURM16_CONSTS_SVH
`define SLURM16_CONSTS_SVH

// Datapath and register select widths
`define SLURM16_BITS         16
`define SLURM16_REG_BITS     4
`define SLURM16_CLASS_BITS   4

// Fixed register numbers
`define SLURM16_LINK_REG     15
`define SLURM16_ILINK_REG    14

// Default instruction queue depth, power of two
`define SLURM16_QUEUE_DEPTH  4

// Field positions inside an instruction word
`define SLURM16_DEST_LSB     4
`define SLURM16_SRC_LSB      0
`define SLURM16_INDEX_LSB    8
`define SLURM16_IRET_BIT     0

// Instruction class codes from bits 15..12
`define SLURM16_CLASS_NOP             4'd0
`define SLURM16_CLASS_RET_IRET        4'd1
`define SLURM16_CLASS_ALU_SINGLE      4'd2
`define SLURM16_CLASS_ALU_REG_REG     4'd3
`define SLURM16_CLASS_COND_ALU_THREE  4'd4
`define SLURM16_CLASS_COND_MOV        4'd5
`define SLURM16_CLASS_ALU_REG_IMM     4'd6
`define SLURM16_CLASS_BRANCH          4'd7
`define SLURM16_CLASS_LOAD_STORE      4'd8
`define SLURM16_CLASS_BYTE_LOAD_STORE 4'd9
`define SLURM16_CLASS_BYTE_LOAD_SX    4'd10
`define SLURM16_CLASS_PEEK_POKE       4'd11

`endif

// File: verilog/slurm16_isa_pkg.sv
// Instruction set types only, class codes 12 to 15 have no enum name and decode as undefined
`default_nettype none

`include "slurm16_consts.svh"

package slurm16_isa_pkg;

	// ******************************
	// Word and register types
	// ******************************

	// One instruction word as fetched
	typedef logic [`SLURM16_BITS-1:0] instruction_t;

	// Register number, r0 reads as zero
	typedef logic [`SLURM16_REG_BITS-1:0] reg_sel_t;

	// Register contents
	typedef logic [`SLURM16_BITS-1:0] reg_data_t;

	// ******************************
	// Instruction classes
	// ******************************

	// Top nibble of the word selects the class
	typedef enum logic [`SLURM16_CLASS_BITS-1:0] {
		cls_nop             = `SLURM16_CLASS_NOP,
		cls_ret_iret        = `SLURM16_CLASS_RET_IRET,
		cls_alu_single      = `SLURM16_CLASS_ALU_SINGLE,
		cls_alu_reg_reg     = `SLURM16_CLASS_ALU_REG_REG,
		cls_cond_alu_three  = `SLURM16_CLASS_COND_ALU_THREE,
		cls_cond_mov        = `SLURM16_CLASS_COND_MOV,
		cls_alu_reg_imm     = `SLURM16_CLASS_ALU_REG_IMM,
		cls_branch          = `SLURM16_CLASS_BRANCH,
		cls_load_store      = `SLURM16_CLASS_LOAD_STORE,
		cls_byte_load_store = `SLURM16_CLASS_BYTE_LOAD_STORE,
		cls_byte_load_sx    = `SLURM16_CLASS_BYTE_LOAD_SX,
		cls_peek_poke       = `SLURM16_CLASS_PEEK_POKE
	} ins_class_t;

endpackage

`default_nettype wire

// File: verilog/slurm16_pipe_pkg.sv
// Pipeline control types, qptr_t is sized for the default queue depth only
`default_nettype none

`include "slurm16_consts.svh"

package slurm16_pipe_pkg;

	// Four-phase handshake progress, shared by intake and output port
	typedef enum logic [1:0] {
		idle,
		req_high,
		wait_ack_low
	} hs_state_t;

	// Queue pointer with one wrap bit above the index
	typedef logic [$clog2(`SLURM16_QUEUE_DEPTH):0] qptr_t;

endpackage

`default_nettype wire

// File: verilog/slurm16_ins_intake.sv
// Sender must hold in_ins stable while in_req is high; one word per full four-phase cycle
`timescale 1ns/10ps
`default_nettype none

module slurm16_ins_intake
	import slurm16_isa_pkg::*, slurm16_pipe_pkg::*;
(
	input  wire          CLK,
	input  wire          rst,
	input  wire          in_req,
	input  instruction_t in_ins,
	output logic         in_ack,
	output logic         push,
	output instruction_t push_data,
	input  wire          full
);

	hs_state_t state;

	// Push exactly once, only from idle and only with room in the queue
	assign push = (state == idle) && in_req && !full;
	assign push_data = in_ins;

	// Ack follows the state register, one cycle after the push
	assign in_ack = (state == req_high);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (push)
						state <= req_high;
				end
				// Hold ack until the sender lets go of req
				req_high: begin
					if (!in_req)
						state <= wait_ack_low;
				end
				// Ack is low now, one settle cycle before the next word
				wait_ack_low: state <= idle;
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/slurm16_ins_queue.sv
// DEPTH must be 2 or 4 so the index wraps with qptr_t; push when full and pop when empty are dropped
`timescale 1ns/10ps
`default_nettype none

`include "slurm16_consts.svh"

module slurm16_ins_queue
	import slurm16_isa_pkg::*, slurm16_pipe_pkg::*;
#(
	parameter int DEPTH = `SLURM16_QUEUE_DEPTH
) (
	input  wire          CLK,
	input  wire          rst,
	input  wire          push,
	input  instruction_t push_data,
	input  wire          pop,
	output instruction_t pop_data,
	output logic         full,
	output logic         empty
);

	localparam int idx_bits = $clog2(DEPTH);

	instruction_t mem [DEPTH];
	qptr_t        wr_ptr;
	qptr_t        rd_ptr;
	qptr_t        fill;
	logic         do_push;
	logic         do_pop;

	// ******************************
	// Occupancy
	// ******************************

	// Pointer difference gives the word count, wrap bit included
	assign fill = wr_ptr - rd_ptr;
	assign full = (fill == qptr_t'(DEPTH));
	assign empty = (fill == '0);

	// Guard both ends so a stray strobe cannot corrupt the pointers
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Head word is visible without a pop, taken in the pop cycle
	assign pop_data = mem[rd_ptr[idx_bits-1:0]];

	// Storage array
	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr[idx_bits-1:0]] <= push_data;
	end

	// Pointers, push and pop may land in the same cycle
	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + qptr_t'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + qptr_t'(1);
		end
	end

endmodule

`default_nettype wire

// File: verilog/slurm16_cpu_decode.sv
// Purely combinational and any class without register operands selects r0
`timescale 1ns/10ps
`default_nettype none

`include "slurm16_consts.svh"

module slurm16_cpu_decode
	import slurm16_isa_pkg::*;
(
	input  instruction_t instruction,
	output reg_sel_t     reg_a_sel,
	output reg_sel_t     reg_b_sel
);

	ins_class_t ins_class;
	reg_sel_t   dest;
	reg_sel_t   src;
	reg_sel_t   index;
	logic       is_iret;

	// ******************************
	// Field extraction
	// ******************************

	assign ins_class = ins_class_t'(instruction[`SLURM16_BITS-1 -: `SLURM16_CLASS_BITS]);
	assign dest = instruction[`SLURM16_DEST_LSB +: `SLURM16_REG_BITS];
	assign src = instruction[`SLURM16_SRC_LSB +: `SLURM16_REG_BITS];
	assign index = instruction[`SLURM16_INDEX_LSB +: `SLURM16_REG_BITS];

	// Low bit tells iret from ret
	assign is_iret = instruction[`SLURM16_IRET_BIT];

	// ******************************
	// Select per class
	// ******************************

	always_comb begin
		// Default both ports to r0
		reg_a_sel = '0;
		reg_b_sel = '0;

		case (ins_class)
			// Return address from link or interrupt link
			cls_ret_iret: begin
				if (is_iret)
					reg_a_sel = reg_sel_t'(`SLURM16_ILINK_REG);
				else
					reg_a_sel = reg_sel_t'(`SLURM16_LINK_REG);
			end
			// Single operand goes through port B
			cls_alu_single: begin
				reg_b_sel = src;
			end
			// Two register forms
			cls_alu_reg_reg, cls_cond_alu_three, cls_cond_mov: begin
				reg_a_sel = dest;
				reg_b_sel = src;
			end
			cls_alu_reg_imm: begin
				reg_a_sel = dest;
			end
			// Indirect branch target base
			cls_branch: begin
				reg_a_sel = index;
			end
			// Memory and IO, data reg on A and address base on B
			cls_load_store, cls_byte_load_store, cls_byte_load_sx, cls_peek_poke: begin
				reg_a_sel = dest;
				reg_b_sel = index;
			end
			// nop and codes 12 to 15
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/slurm16_operand_fetch.sv
// Register file is written only from outside while idle; a write to r0 is ignored
`timescale 1ns/10ps
`default_nettype none

`include "slurm16_consts.svh"

module slurm16_operand_fetch
	import slurm16_isa_pkg::*, slurm16_pipe_pkg::*;
(
	input  wire          CLK,
	input  wire          rst,
	input  wire          empty,
	output logic         pop,
	input  instruction_t pop_data,
	input  wire          wr_en,
	input  reg_sel_t     wr_sel,
	input  reg_data_t    wr_data,
	output logic         out_req,
	input  wire          out_ack,
	output instruction_t out_ins,
	output reg_sel_t     out_reg_a_sel,
	output reg_sel_t     out_reg_b_sel,
	output reg_data_t    out_reg_a_val,
	output reg_data_t    out_reg_b_val
);

	localparam int num_regs = 2 ** `SLURM16_REG_BITS;

	hs_state_t state;
	// r0 has no storage
	reg_data_t regs [1:num_regs-1];
	reg_sel_t  dec_a_sel;
	reg_sel_t  dec_b_sel;
	reg_data_t rd_a_val;
	reg_data_t rd_b_val;

	slurm16_cpu_decode u_decode (
		.instruction (pop_data),
		.reg_a_sel   (dec_a_sel),
		.reg_b_sel   (dec_b_sel)
	);

	// Take the head word only while the output port is free
	assign pop = !empty && (state == idle);
	assign out_req = (state == req_high);

	// Read ports, r0 forced to zero
	assign rd_a_val = (dec_a_sel == '0) ? '0 : regs[dec_a_sel];
	assign rd_b_val = (dec_b_sel == '0) ? '0 : regs[dec_b_sel];

	// External write port
	always_ff @(posedge CLK) begin
		if (wr_en && (wr_sel != '0))
			regs[wr_sel] <= wr_data;
	end

	// Capture word and operands at pop, held through the handshake
	always_ff @(posedge CLK) begin
		if (pop) begin
			out_ins <= pop_data;
			out_reg_a_sel <= dec_a_sel;
			out_reg_b_sel <= dec_b_sel;
			out_reg_a_val <= rd_a_val;
			out_reg_b_val <= rd_b_val;
		end
	end

	// Output four-phase sequence
	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (pop) state <= req_high;
				req_high: if (out_ack) state <= wait_ack_low;
				wait_ack_low: if (!out_ack) state <= idle;
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/slurm16_decode_top.sv
// Front end only, no execute, writeback or hazard logic; load registers only while the pipe is empty
`timescale 1ns/10ps
`default_nettype none

`include "slurm16_consts.svh"

module slurm16_decode_top
	import slurm16_isa_pkg::*;
(
	input  wire          CLK,
	input  wire          rst,
	input  wire          in_req,
	input  instruction_t in_ins,
	output logic         in_ack,
	input  wire          wr_en,
	input  reg_sel_t     wr_sel,
	input  reg_data_t    wr_data,
	output logic         out_req,
	input  wire          out_ack,
	output instruction_t out_ins,
	output reg_sel_t     out_reg_a_sel,
	output reg_sel_t     out_reg_b_sel,
	output reg_data_t    out_reg_a_val,
	output reg_data_t    out_reg_b_val
);

	// Intake to queue
	logic         push;
	instruction_t push_data;
	logic         full;

	// Queue to operand fetch
	logic         pop;
	instruction_t pop_data;
	logic         empty;

	slurm16_ins_intake u_intake (
		.CLK       (CLK),
		.rst       (rst),
		.in_req    (in_req),
		.in_ins    (in_ins),
		.in_ack    (in_ack),
		.push      (push),
		.push_data (push_data),
		.full      (full)
	);

	slurm16_ins_queue #(
		.DEPTH (`SLURM16_QUEUE_DEPTH)
	) u_queue (
		.CLK       (CLK),
		.rst       (rst),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.full      (full),
		.empty     (empty)
	);

	slurm16_operand_fetch u_fetch (
		.CLK           (CLK),
		.rst           (rst),
		.empty         (empty),
		.pop           (pop),
		.pop_data      (pop_data),
		.wr_en         (wr_en),
		.wr_sel        (wr_sel),
		.wr_data       (wr_data),
		.out_req       (out_req),
		.out_ack       (out_ack),
		.out_ins       (out_ins),
		.out_reg_a_sel (out_reg_a_sel),
		.out_reg_b_sel (out_reg_b_sel),
		.out_reg_a_val (out_reg_a_val),
		.out_reg_b_val (out_reg_b_val)
	);

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
// Clock starts low at time zero; reset is held for reset_cycles rising edges, then released 1 ns later
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
	parameter int reset_cycles = 4
) (
	output logic CLK,
	output logic rst
);

	// 8 ns period
	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Release off the edge, like every other driven input
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge CLK);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: dv/tb_slurm16_decode.sv
// Assumes the default queue depth; registers are loaded before any word reads them
`timescale 1ns/10ps
`default_nettype none

`include "slurm16_consts.svh"

module tb_slurm16_decode
	import slurm16_isa_pkg::*;
();

	localparam int reset_cycles = 4;
	localparam int n_class = 17;
	localparam int n_regs = 24;
	localparam int n_random = 200;
	localparam int n_bp = 10;
	localparam int bp_hold = 60;
	localparam int timeout_cycles = 40 * (n_class + n_regs + n_random + n_bp) + reset_cycles;

	// One expected output beat
	typedef struct packed {
		instruction_t ins;
		reg_sel_t     a_sel;
		reg_sel_t     b_sel;
		reg_data_t    a_val;
		reg_data_t    b_val;
	} expect_t;

	logic         CLK;
	logic         rst;
	logic         in_req;
	instruction_t in_ins;
	logic         in_ack;
	logic         wr_en;
	reg_sel_t     wr_sel;
	reg_data_t    wr_data;
	logic         out_req;
	logic         out_ack;
	instruction_t out_ins;
	reg_sel_t     out_reg_a_sel;
	reg_sel_t     out_reg_b_sel;
	reg_data_t    out_reg_a_val;
	reg_data_t    out_reg_b_val;

	// Scoreboard and model state
	reg_data_t    model_regs [16];
	expect_t      exp_q [$];
	instruction_t stim_q [$];
	int           error_count = 0;
	int           pass_count = 0;
	int           fail_count = 0;
	int           acks_seen = 0;
	int           cycle_count = 0;

	tb_clkgen #(.reset_cycles(reset_cycles)) u_clkgen (.CLK(CLK), .rst(rst));

	slurm16_decode_top uut (
		.CLK           (CLK),
		.rst           (rst),
		.in_req        (in_req),
		.in_ins        (in_ins),
		.in_ack        (in_ack),
		.wr_en         (wr_en),
		.wr_sel        (wr_sel),
		.wr_data       (wr_data),
		.out_req       (out_req),
		.out_ack       (out_ack),
		.out_ins       (out_ins),
		.out_reg_a_sel (out_reg_a_sel),
		.out_reg_b_sel (out_reg_b_sel),
		.out_reg_a_val (out_reg_a_val),
		.out_reg_b_val (out_reg_b_val)
	);

	// Run limit scaled to the words sent
	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout after %0d cycles, the pipeline stopped making progress", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ******************************
	// Helpers
	// ******************************

	// Drive and sample point, 1 ns past the rising edge
	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_field(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	// Register selects per class, returned as {a, b}
	function automatic logic [7:0] predict_selects(input instruction_t ins);
		logic [3:0] cls;
		logic [3:0] dest;
		logic [3:0] src;
		logic [3:0] index;
		logic [3:0] a;
		logic [3:0] b;
		cls = ins[15:12];
		dest = ins[7:4];
		src = ins[3:0];
		index = ins[11:8];
		a = 4'd0;
		b = 4'd0;
		case (cls)
			`SLURM16_CLASS_RET_IRET:
				a = ins[0] ? 4'(`SLURM16_ILINK_REG) : 4'(`SLURM16_LINK_REG);
			`SLURM16_CLASS_ALU_SINGLE:
				b = src;
			`SLURM16_CLASS_ALU_REG_REG, `SLURM16_CLASS_COND_ALU_THREE, `SLURM16_CLASS_COND_MOV: begin
				a = dest;
				b = src;
			end
			`SLURM16_CLASS_ALU_REG_IMM:
				a = dest;
			`SLURM16_CLASS_BRANCH:
				a = index;
			`SLURM16_CLASS_LOAD_STORE, `SLURM16_CLASS_BYTE_LOAD_STORE,
			`SLURM16_CLASS_BYTE_LOAD_SX, `SLURM16_CLASS_PEEK_POKE: begin
				a = dest;
				b = index;
			end
			default: ;
		endcase
		return {a, b};
	endfunction

	// One external write, mirrored in the model
	task automatic write_reg(input reg_sel_t sel, input reg_data_t data);
		wr_en = 1'b1;
		wr_sel = sel;
		wr_data = data;
		next_cycle();
		wr_en = 1'b0;
		if (sel != 4'd0)
			model_regs[sel] = data;
	endtask

	task automatic load_registers();
		int r;
		for (r = 1; r < 16; r++)
			write_reg(4'(r), 16'($urandom));
	endtask

	// ******************************
	// Handshake drivers
	// ******************************

	// Expected beat is queued before the word enters the DUT
	task automatic send_word(input instruction_t ins);
		logic [7:0] sels;
		expect_t    e;
		sels = predict_selects(ins);
		e.ins = ins;
		e.a_sel = sels[7:4];
		e.b_sel = sels[3:0];
		e.a_val = (e.a_sel == 4'd0) ? 16'h0000 : model_regs[e.a_sel];
		e.b_val = (e.b_sel == 4'd0) ? 16'h0000 : model_regs[e.b_sel];
		exp_q.push_back(e);
		in_ins = ins;
		in_req = 1'b1;
		do next_cycle(); while (in_ack !== 1'b1);
		acks_seen++;
		in_req = 1'b0;
		do next_cycle(); while (in_ack !== 1'b0);
	endtask

	task automatic send_list(input int max_gap);
		int i;
		for (i = 0; i < stim_q.size(); i++) begin
			send_word(stim_q[i]);
			repeat ($urandom_range(max_gap, 0)) next_cycle();
		end
	endtask

	// Compare each beat in order, then ack after a random delay
	task automatic receive_words(input int count, input int max_delay);
		int      n;
		expect_t e;
		for (n = 0; n < count; n++) begin
			do next_cycle(); while (out_req !== 1'b1);
			assert (exp_q.size() > 0) else begin
				$display("output word arrived with no word outstanding");
				error_count++;
			end
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				check_field("out_ins", out_ins, e.ins);
				check_field("out_reg_a_sel", 16'(out_reg_a_sel), 16'(e.a_sel));
				check_field("out_reg_b_sel", 16'(out_reg_b_sel), 16'(e.b_sel));
				check_field("out_reg_a_val", out_reg_a_val, e.a_val);
				check_field("out_reg_b_val", out_reg_b_val, e.b_val);
			end
			repeat ($urandom_range(max_delay, 0)) next_cycle();
			out_ack = 1'b1;
			do next_cycle(); while (out_req !== 1'b0);
			out_ack = 1'b0;
		end
	endtask

	task automatic run_stream(input int max_gap, input int max_delay);
		int n_words;
		n_words = stim_q.size();
		fork
			send_list(max_gap);
			receive_words(n_words, max_delay);
		join
	endtask

	// Nothing left over and no stray beat, then the per-test line
	task automatic finish_test(input string name, input int start_errors);
		assert (exp_q.size() == 0) else begin
			$display("%0d expected words never came out", exp_q.size());
			error_count++;
		end
		repeat (3) begin
			next_cycle();
			assert (out_req === 1'b0) else begin
				$display("out_req rose after the last expected word");
				error_count++;
			end
		end
		exp_q.delete();
		if (error_count == start_errors) begin
			pass_count++;
			$display("%-16s done, no errors", name);
		end else begin
			fail_count++;
			$display("%-16s done, %0d errors", name, error_count - start_errors);
		end
	endtask

	// ******************************
	// Test sequence
	// ******************************

	initial begin
		instruction_t word;
		int           i;
		int           start_errors;
		in_req = 1'b0;
		in_ins = '0;
		wr_en = 1'b0;
		wr_sel = '0;
		wr_data = '0;
		out_ack = 1'b0;
		for (i = 0; i < 16; i++)
			model_regs[i] = '0;
		void'($urandom(32'h987eb161));

		// Both ports quiet out of reset
		start_errors = error_count;
		wait (rst === 1'b0);
		next_cycle();
		assert (in_ack === 1'b0) else begin
			$display("in_ack is not low after reset");
			error_count++;
		end
		repeat (20) begin
			assert (out_req === 1'b0) else begin
				$display("out_req rose before any word was sent");
				error_count++;
			end
			next_cycle();
		end
		finish_test("reset", start_errors);

		// Every class once, ret and iret both
		start_errors = error_count;
		load_registers();
		stim_q.delete();
		for (i = 0; i < 16; i++) begin
			word = {4'(i), 12'($urandom)};
			if (i == 1)
				word[0] = 1'b0;
			stim_q.push_back(word);
		end
		stim_q.push_back({`SLURM16_CLASS_RET_IRET, 11'($urandom), 1'b1});
		run_stream(1, 2);
		finish_test("class coverage", start_errors);

		// Fresh values and a write to r0 that must not stick
		start_errors = error_count;
		load_registers();
		write_reg(4'd0, 16'($urandom) | 16'h0001);
		stim_q.delete();
		for (i = 0; i < n_regs; i++) begin
			word = {`SLURM16_CLASS_ALU_REG_REG, 12'($urandom)};
			if (i == 0)
				word[7:0] = 8'h00;
			if (i == 1)
				word[7:4] = 4'h0;
			if (i == 2)
				word[3:0] = 4'h0;
			stim_q.push_back(word);
		end
		run_stream(2, 3);
		finish_test("register values", start_errors);

		start_errors = error_count;
		stim_q.delete();
		for (i = 0; i < n_random; i++)
			stim_q.push_back(16'($urandom));
		run_stream(3, 5);
		finish_test("random stream", start_errors);

		// Stall the output, queue fills, intake must stop acking
		start_errors = error_count;
		stim_q.delete();
		for (i = 0; i < n_bp; i++)
			stim_q.push_back(16'($urandom));
		acks_seen = 0;
		fork
			send_list(0);
			begin
				repeat (bp_hold) next_cycle();
				assert (acks_seen == `SLURM16_QUEUE_DEPTH + 1) else begin
					$display("in_ack rose %0d times while stalled, queue depth plus one allowed",
						acks_seen);
					error_count++;
				end
				assert (out_req === 1'b1) else begin
					$display("out_req dropped while out_ack was withheld");
					error_count++;
				end
				receive_words(n_bp, 2);
			end
		join
		finish_test("back-pressure", start_errors);

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/slurm16_isa_pkg.sv
verilog/slurm16_pipe_pkg.sv
verilog/slurm16_ins_intake.sv
verilog/slurm16_ins_queue.sv
verilog/slurm16_cpu_decode.sv
verilog/slurm16_operand_fetch.sv
verilog/slurm16_decode_top.sv
dv/tb_clkgen.sv
dv/tb_slurm16_decode.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the decode front end testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f sources.f --top-module tb_slurm16_decode -Mdir obj_dir \
	> build.log 2>&1 \
	&& ./obj_dir/Vtb_slurm16_decode > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
